//--- cnn_pkg.sv
package cnn_pkg;

	// ------------------------------------------------------------------------
	// word and field widths
	// ------------------------------------------------------------------------
	localparam int WORD_W   = 32;	// host and FIFO word
	localparam int PIX_W    = 16;	// pixel lives in the low half of a data word
	localparam int OPNUM_W  = 16;	// repeat count field
	localparam int OPTYPE_W = 3;	// opcode field

	// header word layout
	localparam int OPTYPE_LSB = 0;	// op_type in bits 2..0
	localparam int OPNUM_LSB  = 16;	// op_num in bits 31..16

	typedef enum logic [OPTYPE_W-1:0] {
		OP_NOP     = 3'd0,
		OP_MAXPOOL = 3'd1,
		OP_AVEPOOL = 3'd2,
		OP_COPY    = 3'd3	// codes above this behave like OP_NOP
	} op_type_e;

	typedef enum logic {
		CTRL_IDLE,	// waiting for a header at the FIFO head
		CTRL_BUSY	// engine owns the input stream
	} ctrl_state_e;

	typedef enum logic {
		ENG_IDLE,
		ENG_RUN
	} eng_state_e;

endpackage

//--- sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
	parameter int FIFO_DEPTH = 32,
	parameter int WORD_W     = 32
) (
	input  logic                            okClk,
	input  logic                            rst_n,
	input  logic                            wr_en,
	input  logic                            rd_en,
	input  logic [WORD_W-1:0]               wr_data,
	output logic [WORD_W-1:0]               rd_data,
	output logic                            empty,
	output logic                            full,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] count
);

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH+1);

	logic [WORD_W-1:0] mem [FIFO_DEPTH];
	logic [AW-1:0]     wr_ptr;
	logic [AW-1:0]     rd_ptr;
	logic              wr_ok;
	logic              rd_ok;

	// pointers wrap by compare as depth need not be a power of two
	function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
		ptr_next = (ptr == AW'(FIFO_DEPTH-1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty   = (count == '0);
	assign full    = (count == CW'(FIFO_DEPTH));
	assign wr_ok   = wr_en && !full;	// overflow write dropped
	assign rd_ok   = rd_en && !empty;	// underflow read dropped
	assign rd_data = mem[rd_ptr];		// head word visible without a read

	always_ff @(posedge okClk) begin
		if (wr_ok)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= ptr_next(wr_ptr);
			if (rd_ok)
				rd_ptr <= ptr_next(rd_ptr);
			if (wr_ok && !rd_ok)
				count <= count + 1'b1;
			else if (rd_ok && !wr_ok)
				count <= count - 1'b1;
		end
	end

endmodule

//--- host_pipe_in.sv
`timescale 1ns/10ps

module host_pipe_in import cnn_pkg::*; #(
	parameter int FIFO_DEPTH = 32,
	parameter int BLOCK_SIZE = 8,
	parameter int HEADROOM   = 4
) (
	input  logic              okClk,
	input  logic              rst_n,
	input  logic              pipe_in_write,
	input  logic [WORD_W-1:0] pipe_in_data,
	input  logic              in_rd_en,
	output logic              pipe_in_ready,
	output logic [WORD_W-1:0] in_data,
	output logic              in_empty
);

	localparam int CNT_W     = $clog2(FIFO_DEPTH+1);
	localparam int SPACE_MAX = FIFO_DEPTH - HEADROOM - BLOCK_SIZE;	// fill level that still takes a block

	logic [CNT_W-1:0] in_count;

	sync_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.WORD_W     (WORD_W)
	) in_fifo_i (
		.okClk   (okClk),
		.rst_n   (rst_n),
		.wr_en   (pipe_in_write),
		.rd_en   (in_rd_en),
		.wr_data (pipe_in_data),
		.rd_data (in_data),
		.empty   (in_empty),
		.full    (),			// host is throttled well before this
		.count   (in_count)
	);

	// block throttle with headroom for the host's reaction delay
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n)
			pipe_in_ready <= 1'b0;
		else
			pipe_in_ready <= (in_count <= CNT_W'(SPACE_MAX));
	end

endmodule

//--- cmd_ctrl.sv
`timescale 1ns/10ps

module cmd_ctrl import cnn_pkg::*; (
	input  logic               okClk,
	input  logic               rst_n,
	input  logic [WORD_W-1:0]  in_data,
	input  logic               in_empty,
	input  logic               data_pop,
	input  logic               done,
	output logic               in_rd_en,
	output logic               start,
	output op_type_e           op_type,
	output logic [OPNUM_W-1:0] op_num,
	output logic               irq
);

	ctrl_state_e state;
	op_type_e    hdr_op;
	logic        hdr_pop;
	logic        hdr_run;

	// ------------------------------------------------------------------------
	// header decode
	// ------------------------------------------------------------------------
	assign hdr_op  = op_type_e'(in_data[OPTYPE_LSB +: OPTYPE_W]);
	assign hdr_pop = (state == CTRL_IDLE) && !in_empty;	// word at head is a header

	always_comb begin
		case (hdr_op)
			OP_MAXPOOL, OP_AVEPOOL, OP_COPY: hdr_run = 1'b1;
			default:                         hdr_run = 1'b0;	// nop and unknown codes
		endcase
	end

	// engine only pops while busy, so the two never overlap
	assign in_rd_en = hdr_pop | data_pop;

	// ------------------------------------------------------------------------
	// sequencing
	// ------------------------------------------------------------------------
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			state <= CTRL_IDLE;
			start <= 1'b0;
			irq   <= 1'b0;
		end else begin
			start <= 1'b0;
			irq   <= 1'b0;
			case (state)
				CTRL_IDLE: begin
					if (hdr_pop && hdr_run) begin
						state <= CTRL_BUSY;
						start <= 1'b1;	// one cycle after the pop
					end
				end
				CTRL_BUSY: begin
					if (done) begin
						state <= CTRL_IDLE;
						irq   <= 1'b1;
					end
				end
				default: state <= CTRL_IDLE;
			endcase
		end
	end

	// opcode and count stay put for the whole job
	always_ff @(posedge okClk) begin
		if (hdr_pop && hdr_run) begin
			op_type <= hdr_op;
			op_num  <= in_data[OPNUM_LSB +: OPNUM_W];
		end
	end

endmodule

//--- pool_engine.sv
`timescale 1ns/10ps

module pool_engine import cnn_pkg::*; #(
	parameter int POOL_WIN = 4	// power of two so the average is a shift
) (
	input  logic               okClk,
	input  logic               rst_n,
	input  logic               start,
	input  op_type_e           op_type,
	input  logic [OPNUM_W-1:0] op_num,
	input  logic [WORD_W-1:0]  in_data,
	input  logic               in_empty,
	input  logic               res_full,
	output logic               data_pop,
	output logic               res_we,
	output logic [WORD_W-1:0]  res_data,
	output logic               done
);

	localparam int WIN_LOG = $clog2(POOL_WIN);
	localparam int SUM_W   = PIX_W + WIN_LOG;	// full window sum never wraps
	localparam int WCNT_W  = WIN_LOG + 1;

	eng_state_e         state;
	logic [WCNT_W-1:0]  wcnt;	// word within window
	logic [WCNT_W-1:0]  win_end;
	logic [OPNUM_W-1:0] ncnt;	// window within op
	logic [SUM_W-1:0]   acc;
	logic [SUM_W-1:0]   acc_next;
	logic [PIX_W-1:0]   pix;
	logic               win_last;
	logic               op_last;

	assign pix      = in_data[PIX_W-1:0];
	assign win_end  = (op_type == OP_COPY) ? '0 : WCNT_W'(POOL_WIN-1);
	assign data_pop = (state == ENG_RUN) && !in_empty && !res_full;
	assign win_last = (wcnt == win_end);
	assign op_last  = (ncnt == op_num - 1'b1);
	assign res_we   = data_pop && win_last;	// result goes out with the last pop

	// ------------------------------------------------------------------------
	// window datapath including the word being popped
	// ------------------------------------------------------------------------
	always_comb begin
		acc_next = SUM_W'(pix);	// first word of a window
		res_data = in_data;		// copy passes the whole word
		case (op_type)
			OP_MAXPOOL: begin
				if (wcnt != '0 && acc[PIX_W-1:0] > pix)
					acc_next = acc;
				res_data = WORD_W'(acc_next[PIX_W-1:0]);
			end
			OP_AVEPOOL: begin
				if (wcnt != '0)
					acc_next = acc + SUM_W'(pix);
				res_data = WORD_W'(acc_next >> WIN_LOG);
			end
			default: ;
		endcase
	end

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ENG_IDLE;
			done  <= 1'b0;
			wcnt  <= '0;
			ncnt  <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				ENG_IDLE: begin
					wcnt <= '0;
					ncnt <= '0;
					if (start) begin
						if (op_num == '0)
							done <= 1'b1;	// empty job
						else
							state <= ENG_RUN;
					end
				end
				ENG_RUN: begin
					if (data_pop) begin
						if (win_last) begin
							wcnt <= '0;
							ncnt <= ncnt + 1'b1;
						end else begin
							wcnt <= wcnt + 1'b1;
						end
					end
					if (res_we && op_last) begin
						state <= ENG_IDLE;
						done  <= 1'b1;
					end
				end
				default: state <= ENG_IDLE;
			endcase
		end
	end

	// partial window survives a stall untouched
	always_ff @(posedge okClk) begin
		if (data_pop)
			acc <= acc_next;
	end

endmodule

//--- host_pipe_out.sv
`timescale 1ns/10ps

module host_pipe_out import cnn_pkg::*; #(
	parameter int FIFO_DEPTH = 32,
	parameter int BLOCK_SIZE = 8
) (
	input  logic              okClk,
	input  logic              rst_n,
	input  logic              res_we,
	input  logic [WORD_W-1:0] res_data,
	input  logic              pipe_out_read,
	output logic              res_full,
	output logic [WORD_W-1:0] pipe_out_data,
	output logic              pipe_out_ready
);

	localparam int CNT_W = $clog2(FIFO_DEPTH+1);

	logic [CNT_W-1:0] out_count;

	sync_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.WORD_W     (WORD_W)
	) out_fifo_i (
		.okClk   (okClk),
		.rst_n   (rst_n),
		.wr_en   (res_we),
		.rd_en   (pipe_out_read),
		.wr_data (res_data),
		.rd_data (pipe_out_data),	// head word for the host
		.empty   (),				// host reads whole blocks only
		.full    (res_full),		// back-pressure to the engine
		.count   (out_count)
	);

	// a full block is waiting
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n)
			pipe_out_ready <= 1'b0;
		else
			pipe_out_ready <= (out_count >= CNT_W'(BLOCK_SIZE));
	end

endmodule

//--- squeeze_top.sv
`timescale 1ns/10ps

module squeeze_top import cnn_pkg::*; #(
	parameter int FIFO_DEPTH = 32,
	parameter int BLOCK_SIZE = 8,
	parameter int HEADROOM   = 4,
	parameter int POOL_WIN   = 4
) (
	input  logic              okClk,
	input  logic              rst_n,
	input  logic              pipe_in_write,
	input  logic [WORD_W-1:0] pipe_in_data,
	input  logic              pipe_out_read,
	output logic              pipe_in_ready,
	output logic [WORD_W-1:0] pipe_out_data,
	output logic              pipe_out_ready,
	output logic              irq
);

	logic [WORD_W-1:0]  in_data;
	logic               in_empty;
	logic               in_rd_en;
	logic               data_pop;
	logic               start;
	logic               done;
	op_type_e           op_type;
	logic [OPNUM_W-1:0] op_num;
	logic               res_we;
	logic [WORD_W-1:0]  res_data;
	logic               res_full;

	// ------------------------------------------------------------------------
	// input side
	// ------------------------------------------------------------------------
	host_pipe_in #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.BLOCK_SIZE (BLOCK_SIZE),
		.HEADROOM   (HEADROOM)
	) host_pipe_in_i (
		.okClk         (okClk),
		.rst_n         (rst_n),
		.pipe_in_write (pipe_in_write),
		.pipe_in_data  (pipe_in_data),
		.in_rd_en      (in_rd_en),
		.pipe_in_ready (pipe_in_ready),
		.in_data       (in_data),
		.in_empty      (in_empty)
	);

	// ------------------------------------------------------------------------
	// processing
	// ------------------------------------------------------------------------
	cmd_ctrl cmd_ctrl_i (
		.okClk    (okClk),
		.rst_n    (rst_n),
		.in_data  (in_data),
		.in_empty (in_empty),
		.data_pop (data_pop),	// engine pops go through the controller
		.done     (done),
		.in_rd_en (in_rd_en),
		.start    (start),
		.op_type  (op_type),
		.op_num   (op_num),
		.irq      (irq)
	);

	pool_engine #(
		.POOL_WIN (POOL_WIN)
	) pool_engine_i (
		.okClk    (okClk),
		.rst_n    (rst_n),
		.start    (start),
		.op_type  (op_type),
		.op_num   (op_num),
		.in_data  (in_data),
		.in_empty (in_empty),
		.res_full (res_full),
		.data_pop (data_pop),
		.res_we   (res_we),
		.res_data (res_data),
		.done     (done)
	);

	// ------------------------------------------------------------------------
	// output side
	// ------------------------------------------------------------------------
	host_pipe_out #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.BLOCK_SIZE (BLOCK_SIZE)
	) host_pipe_out_i (
		.okClk          (okClk),
		.rst_n          (rst_n),
		.res_we         (res_we),
		.res_data       (res_data),
		.pipe_out_read  (pipe_out_read),
		.res_full       (res_full),
		.pipe_out_data  (pipe_out_data),
		.pipe_out_ready (pipe_out_ready)
	);

endmodule

//--- squeeze_chk.sv
`timescale 1ns/10ps

module squeeze_chk (
	input logic okClk,
	input logic rst_n,
	input logic irq,
	input logic res_we,
	input logic res_full,
	input logic pipe_out_ready
);

	// one pulse per finished operation
	irq_single_pulse: assert property (@(posedge okClk) disable iff (!rst_n)
		irq |=> !irq) else $error("irq high for two cycles in a row");

	no_write_when_full: assert property (@(posedge okClk) disable iff (!rst_n)
		!(res_we && res_full)) else $error("result written into a full output FIFO");

	out_ready_after_reset: assert property (@(posedge okClk)
		$rose(rst_n) |=> !pipe_out_ready) else $error("pipe_out_ready high right after reset");

endmodule

bind squeeze_top squeeze_chk squeeze_chk_i (
	.okClk          (okClk),
	.rst_n          (rst_n),
	.irq            (irq),
	.res_we         (res_we),
	.res_full       (res_full),
	.pipe_out_ready (pipe_out_ready)
);

//--- tb_squeeze_top.sv
`timescale 1ns/10ps

module tb_squeeze_top import cnn_pkg::*; ();

	localparam int FIFO_DEPTH   = 32;
	localparam int BLOCK_SIZE   = 8;
	localparam int HEADROOM     = 4;
	localparam int POOL_WIN     = 4;
	localparam int N_ROWS       = 6;
	localparam int STALL_CYCLES = 16;	// input blocked this long means the engine is stalled

	logic              okClk;
	logic              rst_n;
	logic              pipe_in_write;
	logic [WORD_W-1:0] pipe_in_data;
	logic              pipe_in_ready;
	logic              pipe_out_read;
	logic [WORD_W-1:0] pipe_out_data;
	logic              pipe_out_ready;
	logic              irq;

	// ------------------------------------------------------------------------
	// stimulus table with one operation per row
	// ------------------------------------------------------------------------
	op_type_e row_op   [N_ROWS] = '{OP_MAXPOOL, OP_AVEPOOL, OP_NOP, OP_COPY, OP_AVEPOOL, OP_MAXPOOL};
	int       row_num  [N_ROWS] = '{4, 2, 0, 8, 2, 40};	// last row overfills the result FIFO
	int       row_lo   [N_ROWS] = '{0, 'h1000, 0, 0, 'hFFFF, 0};
	int       row_hi   [N_ROWS] = '{'hFFFF, 'h7FFF, 0, 'hFFFF, 'hFFFF, 'hFFFF};
	bit       row_hold [N_ROWS] = '{0, 0, 0, 0, 0, 1};	// host withholds reads

	logic [WORD_W-1:0] in_words [$];	// header and data words in stream order
	logic [WORD_W-1:0] exp_q [$];		// expected results in order
	int                n_results;
	int                hold_at = -1;
	int                irq_expected = 0;
	int                irq_seen = 0;
	int                cycles = 0;
	int                cycle_limit = 0;
	int unsigned       seed_val;

	squeeze_top #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.BLOCK_SIZE (BLOCK_SIZE),
		.HEADROOM   (HEADROOM),
		.POOL_WIN   (POOL_WIN)
	) squeeze_top_i (
		.okClk          (okClk),
		.rst_n          (rst_n),
		.pipe_in_write  (pipe_in_write),
		.pipe_in_data   (pipe_in_data),
		.pipe_out_read  (pipe_out_read),
		.pipe_in_ready  (pipe_in_ready),
		.pipe_out_data  (pipe_out_data),
		.pipe_out_ready (pipe_out_ready),
		.irq            (irq)
	);

	initial begin
		okClk = 1'b0;
		forever #20 okClk = ~okClk;
	end

	always @(negedge okClk) begin
		if (irq)
			irq_seen++;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	always @(posedge okClk) begin
		cycles++;
		assert (cycles < cycle_limit) else
			fail_run($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
	end

	// headers, data words and the reference results for the whole table
	task automatic build_stream();
		int          r;
		int          w;
		int          k;
		int          win_len;
		int unsigned pix;
		int unsigned best;
		int unsigned sum;
		int unsigned word;
		for (r = 0; r < N_ROWS; r++) begin
			if (row_hold[r])
				hold_at = exp_q.size();
			in_words.push_back((WORD_W'(row_num[r]) << OPNUM_LSB) |
				(WORD_W'(row_op[r]) << OPTYPE_LSB));
			if (row_op[r] != OP_NOP)
				irq_expected++;
			win_len = (row_op[r] == OP_COPY) ? 1 : POOL_WIN;
			for (w = 0; w < row_num[r] && row_op[r] != OP_NOP; w++) begin
				best = 0;
				sum  = 0;
				for (k = 0; k < win_len; k++) begin
					pix  = row_lo[r] + $urandom % (row_hi[r] - row_lo[r] + 1);
					word = ($urandom & 32'hFFFF_0000) | pix;	// upper half is noise for pooling
					in_words.push_back(word);
					if (pix > best)
						best = pix;
					sum += pix;
				end
				case (row_op[r])
					OP_MAXPOOL: exp_q.push_back(best);
					OP_AVEPOOL: exp_q.push_back(sum >> $clog2(POOL_WIN));
					default:    exp_q.push_back(word);
				endcase
			end
		end
		while (in_words.size() % BLOCK_SIZE != 0)
			in_words.push_back('0);	// nop padding completes the last block
		n_results   = exp_q.size();
		cycle_limit = in_words.size() * 4 + 200;
	endtask

	task automatic write_stream();
		int idx;
		int k;
		idx = 0;
		while (idx < in_words.size()) begin
			@(negedge okClk);
			if (pipe_in_ready) begin
				for (k = 0; k < BLOCK_SIZE; k++) begin
					pipe_in_write = 1'b1;
					pipe_in_data  = in_words[idx];
					idx++;
					@(negedge okClk);
				end
				pipe_in_write = 1'b0;	// idle cycle lets the throttle catch up
			end
		end
	endtask

	task automatic read_results();
		int                got;
		int                k;
		int                blocked;
		logic [WORD_W-1:0] exp_word;
		got = 0;
		while (got < n_results) begin
			@(negedge okClk);
			if (got == hold_at) begin
				blocked = 0;
				while (blocked < STALL_CYCLES) begin
					blocked = pipe_in_ready ? 0 : blocked + 1;
					@(negedge okClk);
				end
				assert (pipe_out_ready) else
					fail_run("result FIFO shows no full block while the input is stalled");
				hold_at = -1;
			end
			if (pipe_out_ready) begin
				for (k = 0; k < BLOCK_SIZE; k++) begin
					exp_word = exp_q.pop_front();
					assert (pipe_out_data == exp_word) else
						fail_run($sformatf("FAILED pipe_out_data: got %h, expected %h",
							pipe_out_data, exp_word));
					pipe_out_read = 1'b1;
					got++;
					@(negedge okClk);
				end
				pipe_out_read = 1'b0;
			end
		end
	endtask

	initial begin
		rst_n         = 1'b0;
		pipe_in_write = 1'b0;
		pipe_in_data  = '0;
		pipe_out_read = 1'b0;
		seed_val      = $urandom(47);
		build_stream();
		repeat (2) @(negedge okClk);
		rst_n = 1'b1;
		@(negedge okClk);
		assert (pipe_in_ready) else
			fail_run($sformatf("FAILED pipe_in_ready: got %h, expected %h", pipe_in_ready, 1'b1));
		assert (!pipe_out_ready) else
			fail_run($sformatf("FAILED pipe_out_ready: got %h, expected %h", pipe_out_ready, 1'b0));
		fork
			write_stream();
			read_results();
		join
		repeat (2) @(negedge okClk);	// irq trails the last result by two cycles
		assert (irq_seen == irq_expected) else
			fail_run($sformatf("FAILED irq: got %h pulses, expected %h", irq_seen, irq_expected));
		assert (!pipe_out_ready) else
			fail_run($sformatf("FAILED pipe_out_ready: got %h, expected %h", pipe_out_ready, 1'b0));
		$display("Verification passed");
		$finish;
	end

endmodule

//--- filelist.f
cnn_pkg.sv
sync_fifo.sv
host_pipe_in.sv
cmd_ctrl.sv
pool_engine.sv
host_pipe_out.sv
squeeze_top.sv
squeeze_chk.sv
tb_squeeze_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the squeeze_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_squeeze_top \
	-f filelist.f --Mdir "$BUILD_DIR" -o tb_squeeze_top
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/tb_squeeze_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
	exit 0
fi
exit 1
